//--- cacheSubsys.f
design/cachePkg.sv
design/cacheFillCtrl.sv
design/cacheTagStore.sv
design/cacheDataStore.sv
design/cacheTop.sv
tests/cacheMemModel.sv
tests/cacheTb.sv

//--- tests/cacheTb.sv
`timescale 1ns/1ps

module cacheTb;
   import cachePkg::*;

   localparam int dataW = 16;
   localparam int resetCycles = 8;
   // 8 first reads and rereads, 4 for write hits, 4 for write misses, 6 for LRU
   localparam int directedReqs = 22;
   localparam int randomReqs = 40;
   localparam int cycleLimit = resetCycles + 40 * (directedReqs + randomReqs);

   // what the first cycle of a read should show
   localparam int mustMiss = 0;
   localparam int mustHit = 1;
   localparam int eitherWay = 2;

   logic             clk;
   logic             rstN;
   cacheReqT         cpuReq;
   logic [dataW-1:0] rdData;
   logic             stall;
   memReqT           memReq;
   logic             memGrant;
   memRespT          memResp;

   // reference copy of memory that every write sent to the cache updates
   logic [15:0] shadow [65536];
   integer      seed;
   int          cycleCnt = 0;

   cacheTop #(
      .dataW (dataW)
   ) UUT (
      .clk      (clk),
      .rstN     (rstN),
      .cpuReq   (cpuReq),
      .rdData   (rdData),
      .stall    (stall),
      .memReq   (memReq),
      .memGrant (memGrant),
      .memResp  (memResp)
   );

   cacheMemModel memModel (
      .clk      (clk),
      .memReq   (memReq),
      .memGrant (memGrant),
      .memResp  (memResp)
   );

   function automatic logic [15:0] mkAddr(input logic [5:0] tag, input logic [5:0] setIdx,
                                          input logic [2:0] word);
      return {tag, setIdx, word, 1'b0};
   endfunction

   // memory is addressed in words, so byte offset bit 0 drops off
   function automatic logic [15:0] wordAddrOf(input logic [15:0] addr);
      return {1'b0, addr[15:1]};
   endfunction

   function automatic logic [15:0] blockBaseOf(input logic [15:0] addr);
      return {1'b0, addr[15:4], 3'b000};
   endfunction

   task automatic failNow(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1);
   endtask

   // entered 1 ns after an edge and holds the request until stall drops
   task automatic readAndCheck(input logic [15:0] addr, input int outcome);
      logic [15:0] want;
      logic        firstStall;
      want = shadow[wordAddrOf(addr)];
      cpuReq.addr = addr;
      cpuReq.wrData = 16'h0000;
      cpuReq.rd = 1'b1;
      cpuReq.wr = 1'b0;
      @(negedge clk);
      // a miss shows up as stall in the very first cycle
      firstStall = stall;
      while (stall) begin
         @(negedge clk);
      end
      assert (rdData === want)
         else failNow($sformatf("Mismatch at %0t: rdData for %h is %h, expected %h",
                                $time, addr, rdData, want));
      if (outcome != eitherWay) begin
         assert (firstStall === (outcome == mustMiss))
            else failNow($sformatf("Mismatch at %0t: stall for %h is %b, expected %b",
                                   $time, addr, firstStall, outcome == mustMiss));
      end
      @(posedge clk);
      #1;
   endtask

   task automatic writeThrough(input logic [15:0] addr, input logic [15:0] data);
      logic [15:0] wAddr;
      wAddr = wordAddrOf(addr);
      shadow[wAddr] = data;
      cpuReq.addr = addr;
      cpuReq.wrData = data;
      cpuReq.rd = 1'b0;
      cpuReq.wr = 1'b1;
      @(negedge clk);
      assert (stall)
         else failNow($sformatf("write to %h at %0t did not stall", addr, $time));
      // stall falls in the cycle of the acknowledgement
      while (stall) begin
         @(negedge clk);
      end
      assert (memModel.words[wAddr] === shadow[wAddr])
         else failNow($sformatf("Mismatch at %0t: memory word %h is %h, expected %h",
                                $time, wAddr, memModel.words[wAddr], shadow[wAddr]));
      @(posedge clk);
      #1;
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // a memory request needs the grant and a fill asks for the base of the missing block
   always @(negedge clk) begin
      if (rstN) begin
         assert (memGrant || !(memReq.rd || memReq.wr))
            else failNow($sformatf("memory request raised at %0t while memGrant was low",
                                   $time));
         if (memReq.rd) begin
            assert (memReq.addr === blockBaseOf(cpuReq.addr))
               else failNow($sformatf("Mismatch at %0t: memReq.addr is %h, expected %h",
                                      $time, memReq.addr, blockBaseOf(cpuReq.addr)));
         end
      end
   end

   always @(posedge clk) begin
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt >= cycleLimit) begin
         failNow($sformatf("Timeout: run still busy after %0d cycles", cycleCnt));
      end
   end

   initial begin
      logic [31:0] r;
      logic [15:0] a;
      seed = 32'h9ef2;
      for (int i = 0; i < 65536; i++) begin
         shadow[i] = 16'(i) ^ 16'h5a5a;
      end
      rstN = 1'b0;
      cpuReq = '0;
      repeat (resetCycles) @(posedge clk);
      #1;
      rstN = 1'b1;

      // cold reads fill a block each and rereads come from the cache
      readAndCheck(16'h1234, mustMiss);
      readAndCheck(16'h1234, mustHit);
      readAndCheck(16'h8a5e, mustMiss);
      readAndCheck(16'h8a5e, mustHit);
      readAndCheck(16'hc3f0, mustMiss);
      readAndCheck(16'hc3f0, mustHit);
      readAndCheck(16'h0046, mustMiss);
      readAndCheck(16'h0046, mustHit);

      // write hits update the cached word and memory together
      writeThrough(16'h1234, 16'hbeef);
      readAndCheck(16'h1234, mustHit);
      writeThrough(16'h123c, 16'h0f0f);
      readAndCheck(16'h123c, mustHit);

      // with no allocate the read after such a write has to go to memory
      writeThrough(16'h5578, 16'h1357);
      readAndCheck(16'h5578, mustMiss);
      writeThrough(16'hf00a, 16'h2468);
      readAndCheck(16'hf00a, mustMiss);

      // tags 01 and 02 fill set 2a and touching 01 again leaves 02 as the victim for 03
      readAndCheck(mkAddr(6'h01, 6'h2a, 3'd1), mustMiss);
      readAndCheck(mkAddr(6'h02, 6'h2a, 3'd3), mustMiss);
      readAndCheck(mkAddr(6'h01, 6'h2a, 3'd5), mustHit);
      readAndCheck(mkAddr(6'h03, 6'h2a, 3'd0), mustMiss);
      readAndCheck(mkAddr(6'h01, 6'h2a, 3'd7), mustHit);
      readAndCheck(mkAddr(6'h02, 6'h2a, 3'd2), mustMiss);

      // four tags over four sets keep both ways busy and force evictions
      for (int i = 0; i < randomReqs; i++) begin
         r = $random(seed);
         a = mkAddr({r[1:0], 4'h9}, {4'h0, r[3:2]}, r[6:4]);
         if (r[8]) begin
            writeThrough(a, r[31:16]);
         end else begin
            readAndCheck(a, eitherWay);
         end
      end

      cpuReq.rd = 1'b0;
      cpuReq.wr = 1'b0;
      repeat (2) @(posedge clk);
      $display("Testbench passed");
      $finish;
   end

endmodule

//--- tests/cacheMemModel.sv
`timescale 1ns/1ps

module cacheMemModel (
   input  logic              clk,
   input  cachePkg::memReqT  memReq,
   output logic              memGrant,
   output cachePkg::memRespT memResp
);
   import cachePkg::*;

   // one entry per word address
   logic [15:0] words [65536];
   integer      seed;
   logic        rdSeen;
   logic        wrSeen;
   logic [15:0] reqAddr;

   // one response strobe 1 to 4 cycles after the previous edge
   // it is entered and left 1 ns after a rising edge
   task automatic respond(input logic [15:0] data);
      int lat;
      lat = 1 + int'($unsigned($random(seed)) % 4);
      if (lat > 1) begin
         memResp.valid = 1'b0;
         repeat (lat - 1) begin
            @(posedge clk);
            #1;
         end
      end
      memResp.data = data;
      memResp.valid = 1'b1;
      @(posedge clk);
      #1;
   endtask

   initial begin
      seed = 32'h9ef2;
      for (int i = 0; i < 65536; i++) begin
         words[i] = 16'(i) ^ 16'h5a5a;
      end
      memGrant = 1'b0;
      memResp = '0;
      forever begin
         @(posedge clk);
         // the request is taken at the edge, as the cache sees it
         rdSeen = memGrant & memReq.rd;
         wrSeen = memGrant & memReq.wr;
         reqAddr = memReq.addr;
         if (wrSeen) begin
            words[reqAddr] = memReq.data;
         end
         #1;
         if (rdSeen || wrSeen) begin
            // the bus stays with this cache until its response is over
            memGrant = 1'b0;
            if (rdSeen) begin
               for (int b = 0; b < wordsPerBlock; b++) begin
                  respond(words[reqAddr + 16'(b)]);
               end
            end else begin
               // a single strobe acknowledges the write
               respond(16'h0000);
            end
            memResp.valid = 1'b0;
         end
         // the other cache sharing the memory holds the bus now and then
         memGrant = ($unsigned($random(seed)) % 4) != 0;
      end
   end

endmodule

//--- design/cacheTop.sv
`timescale 1ns/1ps

module cacheTop #(
   parameter int dataW = 16
) (
   input  logic               clk,
   input  logic               rstN,
   input  cachePkg::cacheReqT cpuReq,
   output logic [dataW-1:0]   rdData,
   output logic               stall,
   output cachePkg::memReqT   memReq,
   input  logic               memGrant,
   input  cachePkg::memRespT  memResp
);
   import cachePkg::*;

   tagLookupT        lookup;
   logic             tagWr;
   logic             fillWay;
   logic             fillWordWr;
   logic [wordW-1:0] fillWord;
   logic             hitWordWr;
   logic             touch;
   logic             storeWrEn;
   logic [dataW-1:0] storeWrData;

   // the data store has a single write port shared by fills and write hits
   assign storeWrEn = fillWordWr | hitWordWr;
   // fill words come straight off the memory bus, hit writes from the processor
   assign storeWrData = fillWordWr ? memResp.data : cpuReq.wrData;

   // a read that completes without stall, or a write that lands in the cache,
   // counts as a use of the hit way for LRU purposes
   assign touch = lookup.hit & ((cpuReq.rd & ~stall) | hitWordWr);

   cacheFillCtrl fillCtrl (
      .clk        (clk),
      .rstN       (rstN),
      .cpuReq     (cpuReq),
      .lookup     (lookup),
      .memGrant   (memGrant),
      .memResp    (memResp),
      .memReq     (memReq),
      .stall      (stall),
      .tagWr      (tagWr),
      .fillWay    (fillWay),
      .fillWordWr (fillWordWr),
      .fillWord   (fillWord),
      .hitWordWr  (hitWordWr)
   );

   cacheTagStore tagStore (
      .clk     (clk),
      .rstN    (rstN),
      .addr    (cpuReq.addr),
      .tagWr   (tagWr),
      .fillWay (fillWay),
      .touch   (touch),
      .lookup  (lookup)
   );

   // fillWay follows the hit way outside a fill, so it also steers reads
   cacheDataStore #(
      .dataW (dataW)
   ) dataStore (
      .clk         (clk),
      .addr        (cpuReq.addr),
      .way         (fillWay),
      .wordSel     (fillWord),
      .useFillWord (fillWordWr),
      .wrEn        (storeWrEn),
      .wrData      (storeWrData),
      .rdData      (rdData)
   );

endmodule

//--- design/cacheDataStore.sv
`timescale 1ns/1ps

module cacheDataStore #(
   parameter int dataW = 16
) (
   input  logic                       clk,
   input  logic [15:0]                addr,
   input  logic                       way,
   input  logic [cachePkg::wordW-1:0] wordSel,
   input  logic                       useFillWord,
   input  logic                       wrEn,
   input  logic [dataW-1:0]           wrData,
   output logic [dataW-1:0]           rdData
);
   import cachePkg::*;

   // blocks are laid out as set, then way, then word
   localparam int depth = numSets * 2 * wordsPerBlock;
   localparam int idxW = $clog2(depth);

   logic [dataW-1:0] blockArr [depth];
   logic [wordW-1:0] wordIdx;
   logic [idxW-1:0]  entry;

   // during a fill the controller counts through the block itself,
   // otherwise the word comes from the processor address
   assign wordIdx = useFillWord ? wordSel : addr[wordW:1];

   // set times two plus way picks the block, the word picks the entry
   assign entry = {addr[wordW + setW : wordW + 1], way, wordIdx};

   always_ff @(posedge clk) begin
      if (wrEn) begin
         blockArr[entry] <= wrData;
      end
   end

   // read is combinational so a hit returns data in the request cycle
   assign rdData = blockArr[entry];

endmodule

//--- design/cacheTagStore.sv
`timescale 1ns/1ps

module cacheTagStore (
   input  logic                clk,
   input  logic                rstN,
   input  logic [15:0]         addr,
   input  logic                tagWr,
   input  logic                fillWay,
   input  logic                touch,
   output cachePkg::tagLookupT lookup
);
   import cachePkg::*;

   // index 0 is the even way and index 1 the odd way
   logic [tagW-1:0]             tagArr [2][numSets];
   logic [1:0][numSets-1:0]     validArr;
   // one bit per set naming the way to evict next
   logic [numSets-1:0]          lruArr;

   logic [tagW-1:0] tag;
   logic [setW-1:0] setIdx;
   logic [1:0]      match;
   logic            victim;

   assign tag = addr[15 -: tagW];
   assign setIdx = addr[wordW + setW : wordW + 1];

   // both ways are compared in parallel straight off the flop arrays
   always_comb begin
      for (int w = 0; w < 2; w++) begin
         match[w] = validArr[w][setIdx] & (tagArr[w][setIdx] == tag);
      end
   end

   // an empty way is always filled before anything is evicted
   always_comb begin
      if (!validArr[0][setIdx]) begin
         victim = 1'b0;
      end else if (!validArr[1][setIdx]) begin
         victim = 1'b1;
      end else begin
         victim = lruArr[setIdx];
      end
   end

   assign lookup.hit = |match;
   // tags in one set never repeat, so at most one match bit is set
   assign lookup.hitWay = match[1];
   assign lookup.victimWay = victim;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         validArr <= '0;
         lruArr <= '0;
      end else if (tagWr) begin
         validArr[fillWay][setIdx] <= 1'b1;
         // the freshly filled way is the most recently used
         lruArr[setIdx] <= ~fillWay;
      end else if (touch) begin
         lruArr[setIdx] <= ~lookup.hitWay;
      end
   end

   // tag bits mean nothing until the valid bit is set
   always_ff @(posedge clk) begin
      if (tagWr) begin
         tagArr[fillWay][setIdx] <= tag;
      end
   end

endmodule

//--- design/cacheFillCtrl.sv
`timescale 1ns/1ps

module cacheFillCtrl (
   input  logic                         clk,
   input  logic                         rstN,
   input  cachePkg::cacheReqT           cpuReq,
   input  cachePkg::tagLookupT          lookup,
   input  logic                         memGrant,
   input  cachePkg::memRespT            memResp,
   output cachePkg::memReqT             memReq,
   output logic                         stall,
   output logic                         tagWr,
   output logic                         fillWay,
   output logic                         fillWordWr,
   output logic [cachePkg::wordW-1:0]   fillWord,
   output logic                         hitWordWr
);
   import cachePkg::*;

   typedef enum logic [2:0] {
      idle,
      waitGrantRd,
      filling,
      waitGrantWr,
      waitAck
   } stateT;

   stateT            state;
   stateT            nextState;
   logic             victimReg;
   logic [wordW-1:0] wordCnt;
   logic             readMiss;
   logic             lastWord;
   logic [15:0]      wordAddr;
   logic [15:0]      blockAddr;

   // a write takes priority if the processor ever raises both levels
   assign readMiss = cpuReq.rd & ~cpuReq.wr & ~lookup.hit;
   assign lastWord = (wordCnt == wordW'(wordsPerBlock - 1));

   // memory is word addressed, so the byte offset bit 0 drops off
   assign wordAddr = {1'b0, cpuReq.addr[15:1]};
   // block base keeps tag and set and zeroes the word offset
   assign blockAddr = {1'b0, cpuReq.addr[15 -: tagW + setW], {wordW{1'b0}}};

   // during a fill the latched victim is the target way
   // otherwise the hit way is passed on so the data store reads the right word
   assign fillWay = (state == filling) ? victimReg : lookup.hitWay;
   assign fillWord = wordCnt;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= idle;
         wordCnt <= '0;
      end else begin
         state <= nextState;
         // the counter starts from word 0 at every new fill
         if (state == idle && readMiss) begin
            wordCnt <= '0;
         end else if (fillWordWr) begin
            wordCnt <= wordCnt + 1'b1;
         end
      end
   end

   // victim is sampled once at the miss, later lookups in the same set
   // can change their answer as the LRU bit moves
   always_ff @(posedge clk) begin
      if (state == idle && readMiss) begin
         victimReg <= lookup.victimWay;
      end
   end

   always_comb begin
      nextState = state;
      stall = 1'b1;
      memReq.addr = wordAddr;
      memReq.data = cpuReq.wrData;
      memReq.rd = 1'b0;
      memReq.wr = 1'b0;
      tagWr = 1'b0;
      fillWordWr = 1'b0;
      hitWordWr = 1'b0;

      case (state)
         idle: begin
            // a read hit completes here without stalling
            stall = cpuReq.wr | readMiss;
            if (cpuReq.wr) begin
               // write-through with no allocate, only a hit touches the array
               hitWordWr = lookup.hit;
               nextState = waitGrantWr;
            end else if (readMiss) begin
               nextState = waitGrantRd;
            end
         end

         waitGrantRd: begin
            // the read strobe only goes out while the arbiter grants us the bus
            memReq.addr = blockAddr;
            memReq.rd = memGrant;
            if (memGrant) begin
               nextState = filling;
            end
         end

         filling: begin
            // words come back in ascending order, one per valid strobe
            if (memResp.valid) begin
               fillWordWr = 1'b1;
               if (lastWord) begin
                  // tag goes in on the same edge as the last word
                  // so the next lookup hits and stall drops
                  tagWr = 1'b1;
                  nextState = idle;
               end
            end
         end

         waitGrantWr: begin
            memReq.wr = memGrant;
            if (memGrant) begin
               nextState = waitAck;
            end
         end

         waitAck: begin
            // stall falls in the ack cycle so the processor moves on
            // before the controller is back in idle
            if (memResp.valid) begin
               stall = 1'b0;
               nextState = idle;
            end
         end

         default: begin
            nextState = idle;
         end
      endcase
   end

endmodule

//--- design/cachePkg.sv
package cachePkg;

   // a 16-bit byte address splits into tag, set index and a 4-bit byte offset
   localparam int tagW = 6;
   localparam int setW = 6;
   // word offset inside a block, taken from byte offset bits 3 to 1
   localparam int wordW = 3;

   // each set has an even way and an odd way
   localparam int numSets = 64;
   localparam int wordsPerBlock = 8;

   // processor request, held steady by the processor while stall is high
   typedef struct packed {
      logic [15:0] addr;
      logic [15:0] wrData;
      logic        rd;
      logic        wr;
   } cacheReqT;

   // memory request, addr here is a word address and not a byte address
   typedef struct packed {
      logic [15:0] addr;
      logic [15:0] data;
      logic        rd;
      logic        wr;
   } memReqT;

   // one strobe per returned word, or one strobe to acknowledge a write
   typedef struct packed {
      logic [15:0] data;
      logic        valid;
   } memRespT;

   // victimWay is only meaningful when hit is low
   typedef struct packed {
      logic hit;
      logic hitWay;
      logic victimWay;
   } tagLookupT;

endpackage
